// ==== hdl/ddr_arb_pkg.sv ====
// Shared widths, FIFO depths and types for the DDR read/write arbiter.
// Modules import it inside their bodies and use scoped names in port lists.

`default_nettype none

package ddr_arb_pkg;

        // ----------------------------------------
        // AXI4 bus widths
        // ----------------------------------------
        localparam int AXI_ADDR_WIDTH = 32;    // Byte address
        localparam int AXI_DATA_WIDTH = 128;   // Also the video data width
        localparam int AXI_LEN_WIDTH  = 8;     // AXI4 burst length field

        // ----------------------------------------
        // FIFO depths, as log2 of entries
        // ----------------------------------------
        localparam int WDATA_FIFO_AW = 8;      // 256 write beats
        localparam int WLEN_FIFO_AW  = 2;      // 4 outstanding bursts

        // ----------------------------------------
        // Vector types
        // ----------------------------------------
        typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
        typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;

        // Beats minus one, as on awlen/arlen
        typedef logic [AXI_LEN_WIDTH-1:0] axi_len_t;

        // Request arbiter states
        typedef enum logic [2:0] {
                ARB_IDLE     = 3'd0,   // Waiting for the controller
                ARB_ADDR_CHK = 3'd1,   // Looking at requests
                ARB_WR_ADDR  = 3'd2,   // awvalid up
                ARB_RD_ADDR  = 3'd3,   // arvalid up
                ARB_WAIT     = 3'd4    // One cycle after a handshake
        } arb_state_t;

endpackage

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
// Single-clock first-word-fall-through FIFO.
// The head entry is always visible on head_o while empty_o is low.
// A push when full or a pop when empty has no effect.

`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
        parameter int WIDTH  = 8,
        parameter int ADDR_W = 2
) (
        input  wire logic             ddr_clk_i,
        input  wire logic             resetn_i,
        input  wire logic             push_i,
        input  wire logic [WIDTH-1:0] push_data_i,
        input  wire logic             pop_i,
        output logic      [WIDTH-1:0] head_o,
        output logic                  empty_o,
        output logic                  full_o
);

        localparam int DEPTH = 2 ** ADDR_W;

        logic [WIDTH-1:0]  mem [DEPTH];
        logic [ADDR_W-1:0] wr_ptr;
        logic [ADDR_W-1:0] rd_ptr;
        logic [ADDR_W:0]   count;       // One extra bit to tell full from empty
        logic              do_push;
        logic              do_pop;

        assign do_push = push_i & ~full_o;
        assign do_pop  = pop_i & ~empty_o;

        assign empty_o = (count == '0);
        assign full_o  = (count == (ADDR_W + 1)'(DEPTH));
        assign head_o  = mem[rd_ptr];   // Fall-through read

        // Storage array
        always_ff @(posedge ddr_clk_i)
        begin
                if (do_push)
                begin
                        mem[wr_ptr] <= push_data_i;
                end
        end

        // Pointers and occupancy
        always_ff @(posedge ddr_clk_i or negedge resetn_i)
        begin
                if (!resetn_i)
                begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end
                else
                begin
                        if (do_push)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (do_pop)
                                rd_ptr <= rd_ptr + 1'b1;

                        case ({do_push, do_pop})
                        2'b10:   count <= count + 1'b1;
                        2'b01:   count <= count - 1'b1;
                        default: count <= count;   // Both or neither
                        endcase
                end
        end

endmodule

`default_nettype wire

// ==== hdl/ddr_req_arbiter.sv ====
// Read/write request arbiter driving the AXI AW and AR valids.
// Starts once the DDR controller is ready, then serves one request at a time,
// read before write. Each address handshake is answered by a one-cycle ack.

`timescale 1ns/10ps
`default_nettype none

module ddr_req_arbiter (
        input  wire logic ddr_clk_i,
        input  wire logic resetn_i,
        input  wire logic ddr_ctrl_ready_i,
        input  wire logic wreq_i,
        input  wire logic rreq_i,
        input  wire logic awready_i,
        input  wire logic arready_i,
        input  wire logic wdata_full_i,
        input  wire logic wlen_full_i,
        output logic      awvalid_o,
        output logic      arvalid_o,
        output logic      wlen_push_o,
        output logic      wack_o,
        output logic      rack_o
);

        import ddr_arb_pkg::*;

        arb_state_t state_q;
        logic       wr_ok;

        // Room for the burst data and its length
        assign wr_ok = wreq_i & ~wdata_full_i & ~wlen_full_i;

        // ----------------------------------------
        // Arbiter FSM
        // ----------------------------------------
        always_ff @(posedge ddr_clk_i or negedge resetn_i)
        begin
                if (!resetn_i)
                begin
                        state_q     <= ARB_IDLE;
                        awvalid_o   <= 1'b0;
                        arvalid_o   <= 1'b0;
                        wlen_push_o <= 1'b0;
                        wack_o      <= 1'b0;
                        rack_o      <= 1'b0;
                end
                else
                begin
                        // Single-cycle pulses
                        wlen_push_o <= 1'b0;
                        wack_o      <= 1'b0;
                        rack_o      <= 1'b0;

                        case (state_q)
                        ARB_IDLE:
                        begin
                                if (ddr_ctrl_ready_i)
                                        state_q <= ARB_ADDR_CHK;
                        end

                        ARB_ADDR_CHK:
                        begin
                                if (rreq_i)   // Reads win a tie
                                begin
                                        arvalid_o <= 1'b1;
                                        state_q   <= ARB_RD_ADDR;
                                end
                                else if (wr_ok)
                                begin
                                        awvalid_o   <= 1'b1;
                                        wlen_push_o <= 1'b1;   // Length goes in with AW
                                        state_q     <= ARB_WR_ADDR;
                                end
                        end

                        ARB_WR_ADDR:
                        begin
                                if (awready_i)
                                begin
                                        awvalid_o <= 1'b0;
                                        wack_o    <= 1'b1;
                                        state_q   <= ARB_WAIT;
                                end
                        end

                        ARB_RD_ADDR:
                        begin
                                if (arready_i)
                                begin
                                        arvalid_o <= 1'b0;
                                        rack_o    <= 1'b1;
                                        state_q   <= ARB_WAIT;
                                end
                        end

                        ARB_WAIT:
                        begin
                                // Requester drops its request here
                                state_q <= ARB_ADDR_CHK;
                        end

                        default:
                        begin
                                awvalid_o <= 1'b0;
                                arvalid_o <= 1'b0;
                                state_q   <= ARB_IDLE;
                        end
                        endcase
                end
        end

endmodule

`default_nettype wire

// ==== hdl/wlast_gen.sv ====
// Write beat counter for the W channel.
// Compares the beat index in the current burst with the length at the head
// of the length FIFO, flags the last beat and pops the length on it.

`timescale 1ns/10ps
`default_nettype none

module wlast_gen (
        input  wire logic                 ddr_clk_i,
        input  wire logic                 resetn_i,
        input  wire logic                 wvalid_i,
        input  wire logic                 wready_i,
        input  wire ddr_arb_pkg::axi_len_t len_head_i,
        input  wire logic                 len_empty_i,
        output logic                      wlast_o,
        output logic                      len_pop_o
);

        import ddr_arb_pkg::*;

        axi_len_t beat_cnt_q;   // Beats already accepted in this burst
        logic     beat_fire;
        logic     at_last;

        assign beat_fire = wvalid_i & wready_i;

        // No burst length known means no last beat
        assign at_last = ~len_empty_i & (beat_cnt_q == len_head_i);

        assign wlast_o   = wvalid_i & at_last;
        assign len_pop_o = beat_fire & at_last;   // Burst done

        // ----------------------------------------
        // Beat counter
        // ----------------------------------------
        always_ff @(posedge ddr_clk_i or negedge resetn_i)
        begin
                if (!resetn_i)
                begin
                        beat_cnt_q <= '0;
                end
                else if (beat_fire)
                begin
                        if (at_last)
                                beat_cnt_q <= '0;   // Next burst starts at zero
                        else
                                beat_cnt_q <= beat_cnt_q + 1'b1;
                end
        end

endmodule

`default_nettype wire

// ==== hdl/ddr_rw_arbiter.sv ====
// Top level of the video DMA to DDR AXI4 arbiter.
// Turns read/write burst requests into AXI4 AW, W, AR traffic, buffers write
// data and lengths in FIFOs, and passes read data straight to the video side.

`timescale 1ns/10ps
`default_nettype none

module ddr_rw_arbiter (
        input  wire logic                   ddr_clk_i,
        input  wire logic                   resetn_i,
        input  wire logic                   ddr_ctrl_ready_i,
        // AW channel
        output ddr_arb_pkg::axi_addr_t      awaddr,
        output ddr_arb_pkg::axi_len_t       awlen,
        output logic                        awvalid,
        input  wire logic                   awready,
        // W channel
        output ddr_arb_pkg::axi_data_t      wdata,
        output logic                        wlast,
        output logic                        wvalid,
        input  wire logic                   wready,
        // B channel
        input  wire logic                   bvalid,
        output logic                        bready,
        // AR channel
        output ddr_arb_pkg::axi_addr_t      araddr,
        output ddr_arb_pkg::axi_len_t       arlen,
        output logic                        arvalid,
        input  wire logic                   arready,
        // R channel
        input  wire ddr_arb_pkg::axi_data_t rdata,
        input  wire logic                   rlast,
        input  wire logic                   rvalid,
        output logic                        rready,
        // Video side
        input  wire logic                   wreq_i,
        input  wire ddr_arb_pkg::axi_addr_t wstart_addr_i,
        input  wire ddr_arb_pkg::axi_len_t  beats_to_w_i,
        input  wire ddr_arb_pkg::axi_data_t wdata_i,
        input  wire logic                   wdata_valid_i,
        input  wire logic                   rreq_i,
        input  wire ddr_arb_pkg::axi_addr_t rstart_addr_i,
        input  wire ddr_arb_pkg::axi_len_t  beats_to_r_i,
        output logic                        wdone_o,
        output ddr_arb_pkg::axi_data_t      rdata_o,
        output logic                        rdata_valid_o,
        output logic                        rdone_o,
        output logic                        rack_o,
        output logic                        wack_o
);

        import ddr_arb_pkg::*;

        logic     wdata_empty;
        logic     wdata_full;
        logic     w_fire;
        axi_len_t wlen_head;
        logic     wlen_empty;
        logic     wlen_full;
        logic     wlen_push;
        logic     wlen_pop;
        logic     resp_ready_q;   // Shared rready/bready
        logic     rdone_q;

        // Request fields are held until the ack
        assign awaddr = wstart_addr_i;
        assign awlen  = beats_to_w_i;
        assign araddr = rstart_addr_i;
        assign arlen  = beats_to_r_i;

        assign wvalid = ~wdata_empty;
        assign w_fire = wvalid & wready;

        assign rready        = resp_ready_q;
        assign bready        = resp_ready_q;
        assign rdata_o       = rdata;
        assign rdata_valid_o = rvalid & rready;
        assign wdone_o       = bvalid & bready;   // One pulse per B response
        assign rdone_o       = rdone_q;

        // ----------------------------------------
        // Address channel control
        // ----------------------------------------
        ddr_req_arbiter u_req_arbiter (
                .ddr_clk_i        (ddr_clk_i),
                .resetn_i         (resetn_i),
                .ddr_ctrl_ready_i (ddr_ctrl_ready_i),
                .wreq_i           (wreq_i),
                .rreq_i           (rreq_i),
                .awready_i        (awready),
                .arready_i        (arready),
                .wdata_full_i     (wdata_full),
                .wlen_full_i      (wlen_full),
                .awvalid_o        (awvalid),
                .arvalid_o        (arvalid),
                .wlen_push_o      (wlen_push),
                .wack_o           (wack_o),
                .rack_o           (rack_o)
        );

        // ----------------------------------------
        // Write path
        // ----------------------------------------
        sync_fifo #(
                .WIDTH  (AXI_DATA_WIDTH),
                .ADDR_W (WDATA_FIFO_AW)
        ) wdata_fifo (
                .ddr_clk_i   (ddr_clk_i),
                .resetn_i    (resetn_i),
                .push_i      (wdata_valid_i),
                .push_data_i (wdata_i),
                .pop_i       (w_fire),
                .head_o      (wdata),
                .empty_o     (wdata_empty),
                .full_o      (wdata_full)
        );

        sync_fifo #(
                .WIDTH  (AXI_LEN_WIDTH),
                .ADDR_W (WLEN_FIFO_AW)
        ) wlen_fifo (
                .ddr_clk_i   (ddr_clk_i),
                .resetn_i    (resetn_i),
                .push_i      (wlen_push),
                .push_data_i (beats_to_w_i),
                .pop_i       (wlen_pop),
                .head_o      (wlen_head),
                .empty_o     (wlen_empty),
                .full_o      (wlen_full)
        );

        wlast_gen u_wlast_gen (
                .ddr_clk_i   (ddr_clk_i),
                .resetn_i    (resetn_i),
                .wvalid_i    (wvalid),
                .wready_i    (wready),
                .len_head_i  (wlen_head),
                .len_empty_i (wlen_empty),
                .wlast_o     (wlast),
                .len_pop_o   (wlen_pop)
        );

        // Response readies and read done
        always_ff @(posedge ddr_clk_i or negedge resetn_i)
        begin
                if (!resetn_i)
                begin
                        resp_ready_q <= 1'b0;
                        rdone_q      <= 1'b0;
                end
                else
                begin
                        resp_ready_q <= 1'b1;                      // Always ready after reset
                        rdone_q      <= rvalid & rready & rlast;   // Burst end, one cycle late
                end
        end

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
// Free-running clock for the arbiter testbench.
// Drives a 100 ns period with the first rising edge at 50 ns.

`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
        parameter int HALF_PERIOD_NS = 50
) (
        output logic clk_o
);

        always
        begin
                clk_o = 1'b0;
                #(HALF_PERIOD_NS);
                clk_o = 1'b1;
                #(HALF_PERIOD_NS);
        end

endmodule

`default_nettype wire

// ==== tb/tb_ddr_rw_arbiter.sv ====
// Testbench for the DDR read/write arbiter top level.
// Applies a table of read and write bursts, answers on AXI with a simple slave
// with random readies, and checks addresses, beats, wlast and done pulses.

`timescale 1ns/10ps
`default_nettype none

module tb_ddr_rw_arbiter;

        import ddr_arb_pkg::*;

        localparam int NUM_TESTS = 7;
        localparam logic [1:0] OP_WR = 2'b01;   // Bit 0 write, bit 1 read
        localparam logic [1:0] OP_RD = 2'b10;
        localparam logic [1:0] OP_RW = 2'b11;

        // ----------------------------------------
        // Test table
        // ----------------------------------------
        string     t_name  [NUM_TESTS] = '{"wr_len0", "rd_len0", "wr_len3", "rd_len3",
                                           "wr_len15", "rd_len15", "rw_prio"};
        logic [1:0] t_op   [NUM_TESTS] = '{OP_WR, OP_RD, OP_WR, OP_RD, OP_WR, OP_RD, OP_RW};
        axi_addr_t t_addr  [NUM_TESTS] = '{32'h0000_1000, 32'h0000_2000, 32'h0000_3000,
                                           32'h0000_4000, 32'h0001_0000, 32'h0002_0000,
                                           32'h0003_0000};
        axi_len_t  t_len   [NUM_TESTS] = '{8'd0, 8'd0, 8'd3, 8'd3, 8'd15, 8'd15, 8'd3};
        axi_data_t t_base  [NUM_TESTS] = '{128'hA000, 128'h0, 128'hB000, 128'h0,
                                           128'hC000, 128'h0, 128'hD000};
        int        t_beats [NUM_TESTS] = '{1, 1, 4, 4, 16, 16, 4};   // Expected beats

        logic      ddr_clk_i;
        logic      resetn_i;
        logic      ddr_ctrl_ready_i;
        axi_addr_t awaddr;
        axi_len_t  awlen;
        logic      awvalid;
        logic      awready;
        axi_data_t wdata;
        logic      wlast;
        logic      wvalid;
        logic      wready;
        logic      bvalid;
        logic      bready;
        axi_addr_t araddr;
        axi_len_t  arlen;
        logic      arvalid;
        logic      arready;
        axi_data_t rdata;
        logic      rlast;
        logic      rvalid;
        logic      rready;
        logic      wreq_i;
        axi_addr_t wstart_addr_i;
        axi_len_t  beats_to_w_i;
        axi_data_t wdata_i;
        logic      wdata_valid_i;
        logic      rreq_i;
        axi_addr_t rstart_addr_i;
        axi_len_t  beats_to_r_i;
        logic      wdone_o;
        axi_data_t rdata_o;
        logic      rdata_valid_o;
        logic      rdone_o;
        logic      rack_o;
        logic      wack_o;

        // Current test as seen by the monitor
        string     cur_name;
        axi_addr_t cur_addr;
        axi_len_t  cur_len;
        axi_data_t cur_base;
        int        w_idx;
        int        r_idx;
        logic      aw_seen;

        int wack_cnt;
        int rack_cnt;
        int wdone_cnt;
        int rdone_cnt;
        int err_cnt;
        int tests_run;
        int tests_failed;
        int seed = 32'h6189;

        tb_clk_gen u_clk_gen (
                .clk_o (ddr_clk_i)
        );

        ddr_rw_arbiter dut (
                .ddr_clk_i        (ddr_clk_i),
                .resetn_i         (resetn_i),
                .ddr_ctrl_ready_i (ddr_ctrl_ready_i),
                .awaddr           (awaddr),
                .awlen            (awlen),
                .awvalid          (awvalid),
                .awready          (awready),
                .wdata            (wdata),
                .wlast            (wlast),
                .wvalid           (wvalid),
                .wready           (wready),
                .bvalid           (bvalid),
                .bready           (bready),
                .araddr           (araddr),
                .arlen            (arlen),
                .arvalid          (arvalid),
                .arready          (arready),
                .rdata            (rdata),
                .rlast            (rlast),
                .rvalid           (rvalid),
                .rready           (rready),
                .wreq_i           (wreq_i),
                .wstart_addr_i    (wstart_addr_i),
                .beats_to_w_i     (beats_to_w_i),
                .wdata_i          (wdata_i),
                .wdata_valid_i    (wdata_valid_i),
                .rreq_i           (rreq_i),
                .rstart_addr_i    (rstart_addr_i),
                .beats_to_r_i     (beats_to_r_i),
                .wdone_o          (wdone_o),
                .rdata_o          (rdata_o),
                .rdata_valid_o    (rdata_valid_o),
                .rdone_o          (rdone_o),
                .rack_o           (rack_o),
                .wack_o           (wack_o)
        );

        task automatic check(input string what, input logic [127:0] exp,
                             input logic [127:0] act);
                if (exp !== act)
                begin
                        $display("Fail %s %s expected %h actual %h", cur_name, what, exp, act);
                        err_cnt++;
                end
        endtask

        task automatic report_test(input string name, input int errs);
                tests_run++;
                if (errs == 0)
                begin
                        $display("Test %s ok", name);
                end
                else
                begin
                        $display("Test %s had %0d errors", name, errs);
                        tests_failed++;
                end
        endtask

        // ----------------------------------------
        // AXI slave sampling at the falling edge
        // ----------------------------------------
        initial
        begin
                int        rnd;
                logic      b_next;
                axi_addr_t rd_addr_q;
                int        rd_left;
                int        rd_idx;

                awready = 1'b0;
                wready  = 1'b0;
                arready = 1'b0;
                bvalid  = 1'b0;
                rvalid  = 1'b0;
                rlast   = 1'b0;
                rdata   = '0;
                rd_addr_q = '0;
                rd_left = 0;
                rd_idx  = 0;
                forever
                begin
                        @(negedge ddr_clk_i);
                        b_next = (wvalid && wready && wlast) || (bvalid && !bready);
                        if (rvalid && rready)
                        begin
                                rd_idx++;
                                rd_left--;
                        end
                        if (arvalid && arready)
                        begin
                                rd_addr_q = araddr;
                                rd_left   = int'(arlen) + 1;
                                rd_idx    = 0;
                        end
                        @(posedge ddr_clk_i);
                        #1;
                        rnd     = $random(seed);
                        awready = rnd[0];
                        wready  = rnd[1];
                        arready = rnd[2];
                        bvalid  = b_next;   // B one cycle after last W
                        rvalid  = (rd_left != 0);
                        rlast   = (rd_left == 1);
                        rdata   = axi_data_t'(rd_addr_q) + axi_data_t'(rd_idx);
                end
        end

        // Monitor and pulse counters
        initial
        begin
                forever
                begin
                        @(negedge ddr_clk_i);
                        if (awvalid)
                                aw_seen = 1'b1;
                        if (awvalid && awready)
                        begin
                                check("awaddr", 128'(cur_addr), 128'(awaddr));
                                check("awlen", 128'(cur_len), 128'(awlen));
                        end
                        if (wvalid && wready)
                        begin
                                check("wdata", cur_base + axi_data_t'(w_idx), wdata);
                                check("wlast", 128'(w_idx == int'(cur_len)), 128'(wlast));
                                w_idx++;
                        end
                        if (arvalid && arready)
                        begin
                                check("araddr", 128'(cur_addr), 128'(araddr));
                                check("arlen", 128'(cur_len), 128'(arlen));
                                check("awvalid before AR", 128'(1'b0), 128'(aw_seen));
                        end
                        if (rdata_valid_o)
                        begin
                                check("rdata_o", axi_data_t'(cur_addr) + axi_data_t'(r_idx),
                                      rdata_o);
                                r_idx++;
                        end
                        if (wack_o)
                                wack_cnt++;
                        if (rack_o)
                                rack_cnt++;
                        if (wdone_o)
                                wdone_cnt++;
                        if (rdone_o)
                                rdone_cnt++;
                end
        end

        task automatic check_startup();
                int errs0;

                errs0    = err_cnt;
                cur_name = "startup";
                for (int k = 0; k < 8; k++)
                begin
                        @(posedge ddr_clk_i);
                        #1;
                        wreq_i        = (k < 4);    // Writes first, then reads
                        wstart_addr_i = 32'h0000_0200;
                        rreq_i        = (k >= 4);   // Must wait for the controller
                        rstart_addr_i = 32'h0000_0100;
                        @(negedge ddr_clk_i);
                        check("awvalid", '0, 128'(awvalid));
                        check("arvalid", '0, 128'(arvalid));
                        check("wack_o", '0, 128'(wack_o));
                        check("rack_o", '0, 128'(rack_o));
                        check("rready", 128'(1'b1), 128'(rready));
                        check("bready", 128'(1'b1), 128'(bready));
                end
                @(posedge ddr_clk_i);
                #1;
                wreq_i           = 1'b0;
                rreq_i           = 1'b0;
                ddr_ctrl_ready_i = 1'b1;
                repeat (3) @(posedge ddr_clk_i);
                report_test(cur_name, err_cnt - errs0);
        endtask

        task automatic run_test(input int i);
                int errs0;
                int wack0;
                int rack0;
                int wdone0;
                int rdone0;
                int n_wr;
                int n_rd;

                errs0  = err_cnt;
                wack0  = wack_cnt;
                rack0  = rack_cnt;
                wdone0 = wdone_cnt;
                rdone0 = rdone_cnt;
                n_wr   = t_op[i][0] ? 1 : 0;
                n_rd   = t_op[i][1] ? 1 : 0;
                @(posedge ddr_clk_i);
                #1;
                cur_name = t_name[i];
                cur_addr = t_addr[i];
                cur_len  = t_len[i];
                cur_base = t_base[i];
                w_idx    = 0;
                r_idx    = 0;
                aw_seen  = 1'b0;
                rreq_i        = t_op[i][1];
                rstart_addr_i = cur_addr;
                beats_to_r_i  = cur_len;
                wreq_i        = t_op[i][0];
                wstart_addr_i = cur_addr;
                beats_to_w_i  = cur_len;
                if (n_rd == 1)
                begin
                        do @(negedge ddr_clk_i); while (!rack_o);
                        @(posedge ddr_clk_i);
                        #1;
                        rreq_i = 1'b0;
                end
                if (n_wr == 1)
                begin
                        do @(negedge ddr_clk_i); while (!wack_o);
                        @(posedge ddr_clk_i);
                        #1;
                        wreq_i = 1'b0;
                        for (int b = 0; b <= int'(cur_len); b++)
                        begin
                                wdata_valid_i = 1'b1;
                                wdata_i       = cur_base + axi_data_t'(b);
                                @(posedge ddr_clk_i);
                                #1;
                        end
                        wdata_valid_i = 1'b0;
                end
                while ((wdone_cnt - wdone0 < n_wr) || (rdone_cnt - rdone0 < n_rd))
                        @(negedge ddr_clk_i);
                repeat (4) @(negedge ddr_clk_i);   // Catch extra pulses
                check("wack count", 128'(n_wr), 128'(wack_cnt - wack0));
                check("rack count", 128'(n_rd), 128'(rack_cnt - rack0));
                check("wdone count", 128'(n_wr), 128'(wdone_cnt - wdone0));
                check("rdone count", 128'(n_rd), 128'(rdone_cnt - rdone0));
                check("W beats", 128'(n_wr * t_beats[i]), 128'(w_idx));
                check("R beats", 128'(n_rd * t_beats[i]), 128'(r_idx));
                report_test(cur_name, err_cnt - errs0);
        endtask

        // ----------------------------------------
        // Main sequence
        // ----------------------------------------
        initial
        begin
                resetn_i         = 1'b0;
                ddr_ctrl_ready_i = 1'b0;
                wreq_i           = 1'b0;
                wstart_addr_i    = '0;
                beats_to_w_i     = '0;
                wdata_i          = '0;
                wdata_valid_i    = 1'b0;
                rreq_i           = 1'b0;
                rstart_addr_i    = '0;
                beats_to_r_i     = '0;
                cur_name = "reset";
                cur_addr = '0;
                cur_len  = '0;
                cur_base = '0;
                w_idx    = 0;
                r_idx    = 0;
                aw_seen  = 1'b0;
                repeat (10) @(posedge ddr_clk_i);
                #1;
                resetn_i = 1'b1;
                check_startup();
                for (int i = 0; i < NUM_TESTS; i++)
                        run_test(i);
                $display("Tests run %0d, failed %0d, check errors %0d",
                         tests_run, tests_failed, err_cnt);
                if (err_cnt == 0 && tests_failed == 0)
                        $display("*** PASSED ***");
                else
                        $display("*** FAILED ***");
                $finish;
        end

        // Watchdog sized from the table length
        initial
        begin
                arb_state_t st;

                repeat (NUM_TESTS * 40 + 100) @(posedge ddr_clk_i);
                st = dut.u_req_arbiter.state_q;
                $display("Timeout in test %s, arbiter state %s", cur_name, st.name());
                $display("*** FAILED ***");
                $finish;
        end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/ddr_arb_pkg.sv
hdl/sync_fifo.sv
hdl/ddr_req_arbiter.sv
hdl/wlast_gen.sv
hdl/ddr_rw_arbiter.sv
tb/tb_clk_gen.sv
tb/tb_ddr_rw_arbiter.sv

// ==== Makefile ====
# Verilator build and run of the DDR arbiter testbench
TOP = tb_ddr_rw_arbiter

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir

# The result is taken from the log, not from the exit code
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
